/* Bender.yml */
package:
  name: spi_master

sources:
  - files:
      - logic/spi_bus_pkg.sv
      - logic/spi_link_pkg.sv
      - logic/spi_clock_divider.sv
      - logic/spi_shift_engine.sv
      - logic/spi_byte_fifo.sv
      - logic/spi_register_file.sv
      - logic/spi_master_top.sv
  - target: simulation
    files:
      - bench/spi_slave_model.sv
      - bench/spi_master_tb.sv

/* bench/spi_master_tb.sv */
// spi master testbench
module spi_master_tb import spi_bus_pkg::*; import spi_link_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int DIVIDER_WIDTH   = 16;
	localparam int FIFO_DEPTH      = 4;
	localparam int CLK_PERIOD      = 8;
	// largest divider written by the test data
	localparam int MAX_DIVIDER     = 7;
	localparam int BYTE_CYCLES     = 16 * (MAX_DIVIDER + 2) + 4;
	localparam int POLL_LIMIT      = (FIFO_DEPTH + 1) * BYTE_CYCLES;
	localparam int WATCHDOG_MARGIN = 500;

	logic          clk = 1'b0;
	logic          reset;
	spi_bus_req_t  bus_req;
	spi_reg_word_u rd_data;
	spi_pins_t     pins;
	logic          miso;

	// operations from the data file
	string       op_name[$];
	string       op_kind[$];
	logic [1:0]  op_addr[$];
	logic [31:0] op_data[$];
	logic [31:0] op_expect[$];
	logic        ops_loaded = 1'b0;

	logic [31:0] lfsr_state;
	logic        cs_level;

	spi_master_top #(
		.DIVIDER_WIDTH(DIVIDER_WIDTH),
		.FIFO_DEPTH   (FIFO_DEPTH)
	) dut (
		.clk     (clk),
		.reset   (reset),
		.bus_req (bus_req),
		.rd_data (rd_data),
		.pins    (pins),
		.miso    (miso)
	);

	spi_slave_model slave (
		.pins (pins),
		.miso (miso)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ----------------------------------------
	// failure and compare tasks
	// ----------------------------------------
	task automatic report_failure(string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_word(string name, spi_reg_word_u exp, spi_reg_word_u act);
		if (act !== exp) begin
			report_failure($sformatf("mismatch in %s, expected %08h, actual %08h",
				name, exp, act));
		end
	endtask

	task automatic check_status(string name, spi_status_t exp, spi_status_t act);
		if (act !== exp) begin
			report_failure($sformatf("mismatch in %s, expected status %08h, actual %08h",
				name, exp, act));
		end
	endtask

	// only bits set in care are compared
	task automatic check_pins(string name, spi_pins_t exp, spi_pins_t act, spi_pins_t care);
		if ((act & care) !== (exp & care)) begin
			report_failure($sformatf("mismatch in %s, expected pins %03b, actual %03b",
				name, exp & care, act & care));
		end
	endtask

	// ----------------------------------------
	// stimulus helpers
	// ----------------------------------------
	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic idle_gap();
		int gap;
		gap = 0;
		repeat (2) begin
			lfsr_state = lfsr_step(lfsr_state);
			gap = (gap << 1) | lfsr_state[0];
		end
		repeat (gap) @(negedge clk);
	endtask

	// called and returning on a falling edge
	task automatic bus_write(spi_addr_e addr, logic [31:0] data);
		bus_req.wr    = 1'b1;
		bus_req.rd    = 1'b0;
		bus_req.addr  = addr;
		bus_req.wdata = data;
		@(negedge clk);
		bus_req = '0;
	endtask

	task automatic bus_read(spi_addr_e addr, output spi_reg_word_u word);
		bus_req.wr    = 1'b0;
		bus_req.rd    = 1'b1;
		bus_req.addr  = addr;
		bus_req.wdata = '0;
		@(negedge clk);
		bus_req = '0;
		word    = rd_data;
	endtask

	// idle means engine stopped and transmit queue drained
	task automatic poll_idle(string name, spi_status_t exp);
		spi_reg_word_u word;
		spi_status_t   status;
		spi_pins_t     pins_exp;
		spi_pins_t     care;
		int            polls;
		polls = 0;
		do begin
			bus_read(REG_STATUS, word);
			status = spi_status_t'(word);
			polls++;
			if (polls > POLL_LIMIT) begin
				report_failure($sformatf("%s never went idle after %0d status polls",
					name, polls));
			end
		end while (status.busy || !status.tx_empty);
		check_status(name, exp, status);
		pins_exp.sclk = 1'b0;
		pins_exp.mosi = 1'b0;
		pins_exp.cs_n = ~cs_level;
		care.sclk     = 1'b1;
		care.mosi     = 1'b0;
		care.cs_n     = 1'b1;
		check_pins(name, pins_exp, pins, care);
	endtask

	task automatic check_reset_pins();
		spi_pins_t pins_exp;
		spi_pins_t care;
		pins_exp.sclk = 1'b0;
		pins_exp.mosi = 1'b0;
		pins_exp.cs_n = 1'b1;
		care.sclk     = 1'b1;
		care.mosi     = 1'b0;
		care.cs_n     = 1'b1;
		check_pins("reset_pins", pins_exp, pins, care);
	endtask

	// ----------------------------------------
	// test data
	// ----------------------------------------
	task automatic load_tests();
		int          fd;
		int          got;
		string       line;
		string       name;
		string       kind;
		logic [1:0]  addr;
		logic [31:0] data;
		logic [31:0] exp_val;
		fd = $fopen("bench/spi_testdata.txt", "r");
		if (fd == 0) begin
			report_failure("could not open the test data file");
		end
		while (!$feof(fd)) begin
			line = "";
			got  = $fgets(line, fd);
			if (got == 0) begin
				break;
			end
			if (line.len() < 2 || line[0] == "#") begin
				continue;
			end
			got = $sscanf(line, "%s %s %h %h %h", name, kind, addr, data, exp_val);
			if (got != 5) begin
				report_failure($sformatf("malformed test data line: %s", line));
			end
			op_name.push_back(name);
			op_kind.push_back(kind);
			op_addr.push_back(addr);
			op_data.push_back(data);
			op_expect.push_back(exp_val);
		end
		$fclose(fd);
	endtask

	task automatic run_op(int idx);
		spi_reg_word_u word;
		spi_addr_e     addr;
		addr = spi_addr_e'(op_addr[idx]);
		if (op_kind[idx] == "wr") begin
			if (addr == REG_CTRL) begin
				word     = op_data[idx];
				cs_level = word.ctrl.cs_active;
			end
			bus_write(addr, op_data[idx]);
		end else if (op_kind[idx] == "rd") begin
			bus_read(addr, word);
			if (addr == REG_STATUS) begin
				check_status(op_name[idx], spi_status_t'(op_expect[idx]), spi_status_t'(word));
			end else begin
				check_word(op_name[idx], spi_reg_word_u'(op_expect[idx]), word);
			end
		end else if (op_kind[idx] == "poll") begin
			poll_idle(op_name[idx], spi_status_t'(op_expect[idx]));
		end else begin
			report_failure($sformatf("unknown operation %s in %s", op_kind[idx], op_name[idx]));
		end
	endtask

	// ----------------------------------------
	// main sequence and watchdog
	// ----------------------------------------
	initial begin
		bus_req    = '0;
		reset      = 1'b1;
		lfsr_state = 32'h62b7_be92;
		cs_level   = 1'b0;
		load_tests();
		ops_loaded = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_reset_pins();
		for (int i = 0; i < op_name.size(); i++) begin
			idle_gap();
			run_op(i);
		end
		$display("Test passed");
		$finish;
	end

	initial begin
		wait (ops_loaded);
		repeat (op_name.size() * 16 * (MAX_DIVIDER + 2) + WATCHDOG_MARGIN) @(posedge clk);
		report_failure("watchdog expired before all test operations were done");
	end

endmodule

/* bench/spi_slave_model.sv */
// spi mode 0 echo slave
module spi_slave_model import spi_link_pkg::*; (
	input  spi_pins_t pins,
	output logic      miso
);

	timeunit 1ns;
	timeprecision 1ps;

	logic       sclk;
	logic       mosi;
	logic       cs_n;
	spi_byte_t  shift_in;
	spi_byte_t  shift_out;
	spi_byte_t  last_rx;
	logic [2:0] bit_count;

	assign sclk = pins.sclk;
	assign mosi = pins.mosi;
	assign cs_n = pins.cs_n;

	// nothing received yet, so the first echo is zero
	initial begin
		shift_in  = '0;
		shift_out = '0;
		last_rx   = '0;
		bit_count = '0;
	end

	// ----------------------------------------
	// receive on rising sclk
	// ----------------------------------------
	always @(posedge sclk or posedge cs_n) begin
		if (cs_n) begin
			bit_count <= '0;
		end else begin
			shift_in  <= {shift_in[6:0], mosi};
			bit_count <= bit_count + 1'b1;
			if (bit_count == 3'd7) begin
				last_rx <= {shift_in[6:0], mosi};
			end
		end
	end

	// byte boundary reloads the echo, otherwise next bit out
	always @(negedge sclk) begin
		if (!cs_n) begin
			if (bit_count == 3'd0) begin
				shift_out <= last_rx;
			end else begin
				shift_out <= {shift_out[6:0], 1'b0};
			end
		end
	end

	assign miso = cs_n ? 1'b0 : shift_out[7];

endmodule

/* bench/spi_testdata.txt */
# name op addr data expected, op is wr rd or poll, values in hex
# addr 0 ctrl 1 status 2 txdata 3 rxdata, poll expects the idle status word
rst_status      rd   1 00000000 0000000C
rst_ctrl        rd   0 00000000 00000000
ctrl_div3       wr   0 00010003 00000000
ctrl_readback   rd   0 00000000 00010003
tx_a5           wr   2 000000A5 00000000
idle_a5         poll 1 00000000 00000004
echo_first      rd   3 00000000 00000000
tx_3c           wr   2 0000003C 00000000
idle_3c         poll 1 00000000 00000004
echo_a5         rd   3 00000000 000000A5
ctrl_div0       wr   0 00010000 00000000
tx_81           wr   2 00000081 00000000
idle_81         poll 1 00000000 00000004
echo_3c         rd   3 00000000 0000003C
ctrl_div7       wr   0 00010007 00000000
tx_5e           wr   2 0000005E 00000000
idle_5e         poll 1 00000000 00000004
echo_81         rd   3 00000000 00000081
fill_11         wr   2 00000011 00000000
fill_22         wr   2 00000022 00000000
fill_33         wr   2 00000033 00000000
fill_44         wr   2 00000044 00000000
fill_55         wr   2 00000055 00000000
fill_66         wr   2 00000066 00000000
overrun_set     rd   1 00000000 0000002B
overrun_clear   rd   1 00000000 0000000B
idle_burst      poll 1 00000000 00000014
burst_5e        rd   3 00000000 0000005E
burst_11        rd   3 00000000 00000011
burst_22        rd   3 00000000 00000022
burst_33        rd   3 00000000 00000033
rx_empty_read   rd   3 00000000 00000000
rx_empty_status rd   1 00000000 0000000C
cs_release      wr   0 00000000 00000000
ctrl_cleared    rd   0 00000000 00000000
idle_end        poll 1 00000000 0000000C

/* logic/spi_bus_pkg.sv */
// spi register bus definitions
package spi_bus_pkg;

	// ----------------------------------------
	// register map
	// ----------------------------------------
	typedef enum logic [1:0] {
		REG_CTRL   = 2'd0,
		REG_STATUS = 2'd1,
		REG_TXDATA = 2'd2,
		REG_RXDATA = 2'd3
	} spi_addr_e;

	// one processor access, strobes are single cycle
	typedef struct packed {
		logic        wr;
		logic        rd;
		spi_addr_e   addr;
		logic [31:0] wdata;
	} spi_bus_req_t;

	// ----------------------------------------
	// register word views
	// ----------------------------------------
	// cs_active set drives cs_n low
	typedef struct packed {
		logic [14:0] reserved;
		logic        cs_active;
		logic [15:0] divider;
	} spi_ctrl_view_t;

	typedef struct packed {
		logic [23:0] reserved;
		logic [7:0]  data;
	} spi_data_view_t;

	typedef union packed {
		spi_ctrl_view_t ctrl;
		spi_data_view_t data;
	} spi_reg_word_u;

	// status word, busy in bit 0
	typedef struct packed {
		logic [25:0] pad;
		logic        tx_overrun;
		logic        rx_full;
		logic        rx_empty;
		logic        tx_empty;
		logic        tx_full;
		logic        busy;
	} spi_status_t;

endpackage

/* logic/spi_byte_fifo.sv */
// spi byte queue
module spi_byte_fifo import spi_link_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic      clk,
	input  logic      reset,
	input  logic      push,
	input  spi_byte_t push_byte,
	input  logic      pop,
	output spi_byte_t pop_byte,
	output logic      empty,
	output logic      full
);

	localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

	spi_byte_t             mem [FIFO_DEPTH];
	logic [ADDR_WIDTH:0]   wr_ptr_q;
	logic [ADDR_WIDTH:0]   rd_ptr_q;
	logic                  push_ok;
	logic                  pop_ok;

	// ----------------------------------------
	// flags
	// ----------------------------------------
	// top pointer bit tells a full buffer from an empty one
	assign empty = (wr_ptr_q == rd_ptr_q);
	assign full  = (wr_ptr_q[ADDR_WIDTH] != rd_ptr_q[ADDR_WIDTH]) &&
		(wr_ptr_q[ADDR_WIDTH-1:0] == rd_ptr_q[ADDR_WIDTH-1:0]);

	// push on full and pop on empty are ignored
	assign push_ok = push & ~full;
	assign pop_ok  = pop & ~empty;

	// ----------------------------------------
	// pointers
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end else begin
			if (push_ok) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (pop_ok) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (push_ok) begin
			mem[wr_ptr_q[ADDR_WIDTH-1:0]] <= push_byte;
		end
	end

	// head of queue, valid whenever not empty
	assign pop_byte = mem[rd_ptr_q[ADDR_WIDTH-1:0]];

endmodule

/* logic/spi_clock_divider.sv */
// spi shift tick divider
module spi_clock_divider #(
	parameter int DIVIDER_WIDTH = 16
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic [DIVIDER_WIDTH-1:0] divider,
	input  logic                     busy,
	output logic                     tick
);

	logic [DIVIDER_WIDTH-1:0] count_q;
	logic                     tick_q;

	// ----------------------------------------
	// reload counter
	// ----------------------------------------
	// one tick per divider+1 cycles while busy
	always_ff @(posedge clk) begin
		if (reset) begin
			count_q <= '0;
			tick_q  <= 1'b0;
		end else if (busy) begin
			if (count_q == '0) begin
				count_q <= divider;
				tick_q  <= 1'b1;
			end else begin
				count_q <= count_q - 1'b1;
				tick_q  <= 1'b0;
			end
		end else begin
			// idle, keep loaded so the first tick is a full period away
			count_q <= divider;
			tick_q  <= 1'b0;
		end
	end

	assign tick = tick_q;

endmodule

/* logic/spi_link_pkg.sv */
// spi serial link definitions
package spi_link_pkg;

	// ----------------------------------------
	// serial data
	// ----------------------------------------
	// one transfer unit, sent msb first
	typedef logic [7:0] spi_byte_t;

	// ----------------------------------------
	// pins driven by the master
	// ----------------------------------------
	typedef struct packed {
		logic sclk;
		logic mosi;
		logic cs_n;
	} spi_pins_t;

	// ----------------------------------------
	// shift engine outputs
	// ----------------------------------------
	// rx_strobe qualifies rx_byte for one cycle
	typedef struct packed {
		logic      busy;
		logic      rx_strobe;
		spi_byte_t rx_byte;
	} spi_engine_status_t;

endpackage

/* logic/spi_master_top.sv */
// spi master subsystem
module spi_master_top import spi_bus_pkg::*; import spi_link_pkg::*; #(
	parameter int DIVIDER_WIDTH = 16,
	parameter int FIFO_DEPTH    = 4
) (
	input  logic          clk,
	input  logic          reset,
	input  spi_bus_req_t  bus_req,
	output spi_reg_word_u rd_data,
	output spi_pins_t     pins,
	input  logic          miso
);

	logic [DIVIDER_WIDTH-1:0] divider;
	logic                     cs_n;
	logic                     sclk;
	logic                     mosi;
	logic                     tick;

	// transmit side
	logic                     tx_push;
	spi_byte_t                tx_push_byte;
	logic                     tx_pop;
	spi_byte_t                tx_head;
	logic                     tx_empty;
	logic                     tx_full;

	// receive side
	logic                     rx_pop;
	spi_byte_t                rx_head;
	logic                     rx_empty;
	logic                     rx_full;

	spi_engine_status_t       eng;

	// ----------------------------------------
	// processor side
	// ----------------------------------------
	spi_register_file #(
		.DIVIDER_WIDTH(DIVIDER_WIDTH)
	) regs (
		.clk      (clk),
		.reset    (reset),
		.bus_req  (bus_req),
		.rd_data  (rd_data),
		.divider  (divider),
		.cs_n     (cs_n),
		.tx_push  (tx_push),
		.tx_byte  (tx_push_byte),
		.tx_full  (tx_full),
		.tx_empty (tx_empty),
		.rx_pop   (rx_pop),
		.rx_byte  (rx_head),
		.rx_empty (rx_empty),
		.rx_full  (rx_full),
		.busy     (eng.busy)
	);

	// ----------------------------------------
	// queues
	// ----------------------------------------
	spi_byte_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) tx_fifo (
		.clk       (clk),
		.reset     (reset),
		.push      (tx_push),
		.push_byte (tx_push_byte),
		.pop       (tx_pop),
		.pop_byte  (tx_head),
		.empty     (tx_empty),
		.full      (tx_full)
	);

	// bytes arriving on a full queue are lost
	spi_byte_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) rx_fifo (
		.clk       (clk),
		.reset     (reset),
		.push      (eng.rx_strobe),
		.push_byte (eng.rx_byte),
		.pop       (rx_pop),
		.pop_byte  (rx_head),
		.empty     (rx_empty),
		.full      (rx_full)
	);

	// ----------------------------------------
	// serial side
	// ----------------------------------------
	spi_clock_divider #(
		.DIVIDER_WIDTH(DIVIDER_WIDTH)
	) clk_div (
		.clk     (clk),
		.reset   (reset),
		.divider (divider),
		.busy    (eng.busy),
		.tick    (tick)
	);

	spi_shift_engine engine (
		.clk       (clk),
		.reset     (reset),
		.tick      (tick),
		.tx_byte   (tx_head),
		.tx_avail  (~tx_empty),
		.tx_pop    (tx_pop),
		.miso      (miso),
		.sclk      (sclk),
		.mosi      (mosi),
		.rx_byte   (eng.rx_byte),
		.rx_strobe (eng.rx_strobe),
		.busy      (eng.busy)
	);

	assign pins = '{sclk: sclk, mosi: mosi, cs_n: cs_n};

endmodule

/* logic/spi_register_file.sv */
// spi processor register file
module spi_register_file import spi_bus_pkg::*; import spi_link_pkg::*; #(
	parameter int DIVIDER_WIDTH = 16
) (
	input  logic                     clk,
	input  logic                     reset,
	input  spi_bus_req_t             bus_req,
	output spi_reg_word_u            rd_data,
	output logic [DIVIDER_WIDTH-1:0] divider,
	output logic                     cs_n,
	output logic                     tx_push,
	output spi_byte_t                tx_byte,
	input  logic                     tx_full,
	input  logic                     tx_empty,
	output logic                     rx_pop,
	input  spi_byte_t                rx_byte,
	input  logic                     rx_empty,
	input  logic                     rx_full,
	input  logic                     busy
);

	spi_reg_word_u            wr_word;
	spi_reg_word_u            rd_next;
	spi_reg_word_u            rd_data_q;
	spi_status_t              status;
	logic [DIVIDER_WIDTH-1:0] divider_q;
	logic                     cs_active_q;
	logic                     overrun_q;
	logic                     tx_write;

	assign wr_word  = bus_req.wdata;
	assign tx_write = bus_req.wr & (bus_req.addr == REG_TXDATA);

	// ----------------------------------------
	// write side
	// ----------------------------------------
	// full queue drops the byte here
	assign tx_push = tx_write & ~tx_full;
	assign tx_byte = wr_word.data.data;

	always_ff @(posedge clk) begin
		if (reset) begin
			divider_q   <= '0;
			cs_active_q <= 1'b0;
			overrun_q   <= 1'b0;
		end else begin
			if (bus_req.wr && bus_req.addr == REG_CTRL) begin
				divider_q   <= DIVIDER_WIDTH'(wr_word.ctrl.divider);
				cs_active_q <= wr_word.ctrl.cs_active;
			end
			// sticky until status is read
			if (tx_write && tx_full) begin
				overrun_q <= 1'b1;
			end else if (bus_req.rd && bus_req.addr == REG_STATUS) begin
				overrun_q <= 1'b0;
			end
		end
	end

	assign divider = divider_q;
	assign cs_n    = ~cs_active_q;

	// ----------------------------------------
	// read side
	// ----------------------------------------
	assign rx_pop = bus_req.rd & (bus_req.addr == REG_RXDATA) & ~rx_empty;

	always_comb begin
		status            = '0;
		status.busy       = busy;
		status.tx_full    = tx_full;
		status.tx_empty   = tx_empty;
		status.rx_empty   = rx_empty;
		status.rx_full    = rx_full;
		status.tx_overrun = overrun_q;
	end

	always_comb begin
		rd_next = '0;
		case (bus_req.addr)
			REG_CTRL: begin
				rd_next.ctrl.divider   = 16'(divider_q);
				rd_next.ctrl.cs_active = cs_active_q;
			end
			REG_STATUS: rd_next = status;
			// empty queue reads as zero
			REG_RXDATA: begin
				if (!rx_empty) begin
					rd_next.data.data = rx_byte;
				end
			end
			default: rd_next = '0;
		endcase
	end

	// holds until the next read
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_data_q <= '0;
		end else if (bus_req.rd) begin
			rd_data_q <= rd_next;
		end
	end

	assign rd_data = rd_data_q;

endmodule

/* logic/spi_shift_engine.sv */
// spi mode 0 shift engine
module spi_shift_engine import spi_link_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      tick,
	input  spi_byte_t tx_byte,
	input  logic      tx_avail,
	output logic      tx_pop,
	input  logic      miso,
	output logic      sclk,
	output logic      mosi,
	output spi_byte_t rx_byte,
	output logic      rx_strobe,
	output logic      busy
);

	logic      busy_q;
	logic [3:0] phase_q;
	spi_byte_t send_q;
	spi_byte_t recv_q;
	logic      last_tick;

	// ----------------------------------------
	// byte boundary
	// ----------------------------------------
	// 16th tick of a byte, sclk falls for the last time
	assign last_tick = busy_q & tick & (phase_q == 4'd15);

	// take the next byte when idle or when the current one ends
	assign tx_pop = tx_avail & (~busy_q | last_tick);

	// ----------------------------------------
	// shifter
	// ----------------------------------------
	// phase counts ticks taken in this byte
	// odd ticks raise sclk and sample, even ticks lower it and shift
	always_ff @(posedge clk) begin
		if (reset) begin
			busy_q  <= 1'b0;
			phase_q <= 4'd0;
			send_q  <= '0;
		end else if (tx_pop) begin
			busy_q  <= 1'b1;
			phase_q <= 4'd0;
			send_q  <= tx_byte;
		end else if (last_tick) begin
			busy_q  <= 1'b0;
			phase_q <= 4'd0;
		end else if (busy_q && tick) begin
			phase_q <= phase_q + 1'b1;
			if (phase_q[0]) begin
				send_q <= {send_q[6:0], 1'b0};
			end
		end
	end

	// receive path has its own shifter
	always_ff @(posedge clk) begin
		if (busy_q && tick && !phase_q[0]) begin
			recv_q <= {recv_q[6:0], miso};
		end
	end

	// ----------------------------------------
	// outputs
	// ----------------------------------------
	// high between a rising and a falling tick
	assign sclk = phase_q[0];
	assign mosi = send_q[7];

	// all eight samples are in by the last tick
	assign rx_byte   = recv_q;
	assign rx_strobe = last_tick;
	assign busy      = busy_q;

endmodule

/* sim.f */
logic/spi_bus_pkg.sv
logic/spi_link_pkg.sv
logic/spi_clock_divider.sv
logic/spi_shift_engine.sv
logic/spi_byte_fifo.sv
logic/spi_register_file.sv
logic/spi_master_top.sv
bench/spi_slave_model.sv
bench/spi_master_tb.sv
